// File: rtl/playseq_defs.svh
//------------------------------
// sizes and timing of the memory game
// widths below assume a power-of-two depth and bank count
//------------------------------
`ifndef PLAYSEQ_DEFS_SVH
`define PLAYSEQ_DEFS_SVH

// sequence banks
`define PLAYSEQ_DEPTH         16
`define PLAYSEQ_BANKS         4
`define PLAYSEQ_ADDR_W        $clog2(`PLAYSEQ_DEPTH)
`define PLAYSEQ_SEL_W         $clog2(`PLAYSEQ_BANKS)

// one-hot buttons and leds
`define PLAYSEQ_BTN_W         4

// timing, in clock cycles
`define PLAYSEQ_PREVIEW_TICKS 8   // lit time per step, gap is the same
`define PLAYSEQ_TIMEOUT_BASE  16  // press limit at frantic speed

`endif

// File: rtl/playseq_pkg.sv
//------------------------------
// shared types of the game
// round fields hold r-1 for round r, so round 16 fits in 4 bits
//------------------------------
`include "playseq_defs.svh"

package playseq_pkg;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_RECORD,
        ST_SHOW,        // step lit
        ST_GAP,         // dark after a step
        ST_AWAIT,
        ST_CHECK,
        ST_NEXT_ROUND,
        ST_WON,
        ST_LOST
    } game_state_e;

    typedef enum logic [1:0] {LVL_EASY, LVL_MEDIUM, LVL_HARD, LVL_EXPERT} level_e;
    typedef enum logic [1:0] {SPD_RELAXED, SPD_NORMAL, SPD_FAST, SPD_FRANTIC} speed_e;

    typedef struct packed {
        logic clr_addr;
        logic inc_addr;
        logic clr_round;
        logic inc_round;
        logic clr_timer;
        logic run_timer;
    } seq_cmd_t;

    typedef struct packed {
        logic [`PLAYSEQ_ADDR_W-1:0] addr;
        logic [`PLAYSEQ_ADDR_W-1:0] round;   // index of last step shown
        logic                       addr_at_round;
        logic                       final_round;
    } seq_pos_t;

    typedef struct packed {
        logic press;  // one-cycle pulse
        logic match;  // valid the cycle after press
    } judge_t;

    typedef struct packed {
        logic                       playing;
        logic                       awaiting;
        logic                       won;
        logic                       lost;
        logic [`PLAYSEQ_ADDR_W-1:0] round;   // r-1 during round r
    } game_status_t;

endpackage

// File: rtl/seq_bank.sv
//------------------------------
// one recorded button sequence
// read is combinational, so data follows addr in the same cycle
//------------------------------
`timescale 1ns/10ps
`include "playseq_defs.svh"

module seq_bank (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       we,
    input  logic [`PLAYSEQ_ADDR_W-1:0] addr,
    input  logic [`PLAYSEQ_BTN_W-1:0]  wdata,
    output logic [`PLAYSEQ_BTN_W-1:0]  rdata
);

    logic [`PLAYSEQ_BTN_W-1:0] mem [`PLAYSEQ_DEPTH];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PLAYSEQ_DEPTH; i++) begin
                mem[i] <= '0;  // empty bank reads dark
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

    // a write to an unknown address would corrupt the whole bank
    a_we_addr_known: assert property (
        @(posedge clock) disable iff (!arst_n)
        we |-> !$isunknown(addr)
    );

endmodule

// File: rtl/seq_addr_unit.sv
//------------------------------
// step address and round counters
// final round index is {level, 2'b11}, so depth must be 16
//------------------------------
`timescale 1ns/10ps
`include "playseq_defs.svh"

module seq_addr_unit (
    input  logic                        clock,
    input  logic                        arst_n,
    input  playseq_pkg::seq_cmd_t       cmd,
    input  playseq_pkg::level_e         level,
    input  logic [`PLAYSEQ_SEL_W-1:0]   bank_sel,
    input  logic                        rec_write,
    output playseq_pkg::seq_pos_t       pos,
    output logic [`PLAYSEQ_ADDR_W-1:0]  addr,
    output logic [`PLAYSEQ_BANKS-1:0]   bank_we
);

    logic [`PLAYSEQ_ADDR_W-1:0] addr_q;
    logic [`PLAYSEQ_ADDR_W-1:0] round_q;
    logic [`PLAYSEQ_ADDR_W-1:0] final_idx;

    // ------------------------------
    // counters
    // ------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            addr_q <= '0;
        end else if (cmd.clr_addr) begin
            addr_q <= '0;
        end else if (cmd.inc_addr) begin
            addr_q <= addr_q + 1'b1;  // wraps after 15
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            round_q <= '0;
        end else if (cmd.clr_round) begin
            round_q <= '0;
        end else if (cmd.inc_round) begin
            round_q <= round_q + 1'b1;
        end
    end

    // ------------------------------
    // flags and strobes
    // ------------------------------
    assign final_idx = {level, 2'b11};  // 3, 7, 11, 15

    assign pos.addr          = addr_q;
    assign pos.round         = round_q;
    assign pos.addr_at_round = (addr_q == round_q);
    assign pos.final_round   = (round_q == final_idx);

    assign addr    = addr_q;
    assign bank_we = rec_write ? (`PLAYSEQ_BANKS'(1) << bank_sel) : '0;

    // the controller must stop at the last round of the level
    a_round_bound: assert property (
        @(posedge clock) disable iff (!arst_n)
        cmd.inc_round |-> (round_q < final_idx)
    );

endmodule

// File: rtl/move_judge.sv
//------------------------------
// press detection, bank select and step compare
// buttons are taken as clean, one-hot and synchronous
//------------------------------
`timescale 1ns/10ps
`include "playseq_defs.svh"

module move_judge (
    input  logic                                         clock,
    input  logic                                         arst_n,
    input  logic [`PLAYSEQ_BTN_W-1:0]                    buttons,
    input  logic [`PLAYSEQ_BANKS-1:0][`PLAYSEQ_BTN_W-1:0] bank_data,
    input  logic [`PLAYSEQ_SEL_W-1:0]                    bank_sel,
    input  logic                                         preview,
    input  logic                                         leds_on,
    output playseq_pkg::judge_t                          judge,
    output logic [`PLAYSEQ_BTN_W-1:0]                    leds
);

    logic                      any_q;    // buttons held last cycle
    logic                      press;
    logic [`PLAYSEQ_BTN_W-1:0] btn_q;    // value of the last press
    logic [`PLAYSEQ_BTN_W-1:0] sel_data;

    // ------------------------------
    // press edge
    // ------------------------------
    assign press = (|buttons) & ~any_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            any_q <= 1'b0;
        end else begin
            any_q <= |buttons;
        end
    end

    always_ff @(posedge clock) begin
        if (press) begin
            btn_q <= buttons;
        end
    end

    // ------------------------------
    // compare and led source
    // ------------------------------
    assign sel_data = bank_data[bank_sel];

    assign judge.press = press;
    assign judge.match = (btn_q == sel_data);  // meaningful one cycle after press

    always_comb begin
        if (preview) begin
            leds = leds_on ? sel_data : '0;
        end else begin
            leds = buttons;  // echo while playing or recording
        end
    end

endmodule

// File: rtl/play_timer.sv
//------------------------------
// shared preview and press timeout counter
// count saturates at the limit until cleared
//------------------------------
`timescale 1ns/10ps
`include "playseq_defs.svh"

module play_timer (
    input  logic                  clock,
    input  logic                  arst_n,
    input  playseq_pkg::seq_cmd_t cmd,
    input  logic                  preview,
    input  playseq_pkg::speed_e   speed,
    output logic                  tick,
    output logic                  expired
);

    import playseq_pkg::*;

    localparam int CNT_W = $clog2(8 * `PLAYSEQ_TIMEOUT_BASE + 1);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] limit;

    always_comb begin
        unique case (speed)
            SPD_RELAXED: limit = CNT_W'(8 * `PLAYSEQ_TIMEOUT_BASE);
            SPD_NORMAL:  limit = CNT_W'(4 * `PLAYSEQ_TIMEOUT_BASE);
            SPD_FAST:    limit = CNT_W'(2 * `PLAYSEQ_TIMEOUT_BASE);
            default:     limit = CNT_W'(`PLAYSEQ_TIMEOUT_BASE);
        endcase
    end

    assign tick    = preview && cmd.run_timer && (cnt == CNT_W'(`PLAYSEQ_PREVIEW_TICKS - 1));
    assign expired = !preview && (cnt >= limit);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (cmd.clr_timer) begin
            cnt <= '0;
        end else if (cmd.run_timer) begin
            if (tick) begin
                cnt <= '0;          // next preview phase starts fresh
            end else if (!expired) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: rtl/playseq_control.sv
//------------------------------
// game FSM
// won and lost hold until the next start or rising record
//------------------------------
`timescale 1ns/10ps

module playseq_control (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      start,
    input  logic                      record,
    input  playseq_pkg::seq_pos_t     pos,
    input  playseq_pkg::judge_t       judge,
    input  logic                      tick,
    input  logic                      expired,
    output playseq_pkg::seq_cmd_t     cmd,
    output logic                      preview,
    output logic                      leds_on,
    output logic                      rec_write,
    output playseq_pkg::game_status_t status
);

    import playseq_pkg::*;

    game_state_e state;
    game_state_e state_nx;
    logic        record_q;
    logic        rec_rise;

    assign rec_rise = record & ~record_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            record_q <= 1'b0;
        end else begin
            state    <= state_nx;
            record_q <= record;
        end
    end

    // ------------------------------
    // next state and commands
    // ------------------------------
    always_comb begin
        state_nx  = state;
        cmd       = '0;
        rec_write = 1'b0;
        unique case (state)
            ST_IDLE, ST_WON, ST_LOST: begin
                if (start) begin
                    cmd.clr_round = 1'b1;
                    cmd.clr_addr  = 1'b1;
                    cmd.clr_timer = 1'b1;
                    state_nx      = ST_SHOW;
                end else if (rec_rise) begin
                    cmd.clr_addr = 1'b1;
                    state_nx     = ST_RECORD;
                end
            end
            ST_RECORD: begin
                if (!record) begin
                    state_nx = ST_IDLE;
                end else if (judge.press) begin
                    rec_write    = 1'b1;  // store, then step on
                    cmd.inc_addr = 1'b1;
                end
            end
            ST_SHOW: begin
                cmd.run_timer = 1'b1;
                if (tick) state_nx = ST_GAP;
            end
            ST_GAP: begin
                cmd.run_timer = 1'b1;
                if (tick) begin
                    if (pos.addr_at_round) begin  // preview done
                        cmd.clr_addr  = 1'b1;
                        cmd.clr_timer = 1'b1;
                        state_nx      = ST_AWAIT;
                    end else begin
                        cmd.inc_addr = 1'b1;
                        state_nx     = ST_SHOW;
                    end
                end
            end
            ST_AWAIT: begin
                cmd.run_timer = 1'b1;
                if (judge.press) begin
                    state_nx = ST_CHECK;
                end else if (expired) begin
                    state_nx = ST_LOST;
                end
            end
            ST_CHECK: begin
                if (!judge.match) begin
                    state_nx = ST_LOST;
                end else if (pos.addr_at_round) begin
                    state_nx = pos.final_round ? ST_WON : ST_NEXT_ROUND;
                end else begin
                    cmd.inc_addr  = 1'b1;
                    cmd.clr_timer = 1'b1;  // fresh limit per press
                    state_nx      = ST_AWAIT;
                end
            end
            ST_NEXT_ROUND: begin
                cmd.inc_round = 1'b1;
                cmd.clr_addr  = 1'b1;
                cmd.clr_timer = 1'b1;
                state_nx      = ST_SHOW;
            end
            default: state_nx = ST_IDLE;
        endcase
    end

    // ------------------------------
    // outputs
    // ------------------------------
    assign preview = (state == ST_SHOW) || (state == ST_GAP);
    assign leds_on = (state == ST_SHOW);

    assign status.playing  = preview || (state == ST_AWAIT) || (state == ST_CHECK)
                           || (state == ST_NEXT_ROUND);
    assign status.awaiting = (state == ST_AWAIT);
    assign status.won      = (state == ST_WON);
    assign status.lost     = (state == ST_LOST);
    assign status.round    = pos.round;

    a_won_lost_excl: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(status.won && status.lost)
    );

endmodule

// File: rtl/playseq_top.sv
//------------------------------
// memory game top level
// status.round reads r-1 during round r
//------------------------------
`timescale 1ns/10ps
`include "playseq_defs.svh"

module playseq_top (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic                        record,
    input  logic [`PLAYSEQ_SEL_W-1:0]   bank_sel,
    input  playseq_pkg::level_e         level,
    input  playseq_pkg::speed_e         speed,
    input  logic [`PLAYSEQ_BTN_W-1:0]   buttons,
    output logic [`PLAYSEQ_BTN_W-1:0]   leds,
    output playseq_pkg::game_status_t   status
);

    import playseq_pkg::*;

    seq_cmd_t                                      cmd;
    seq_pos_t                                      pos;
    judge_t                                        judge;
    logic                                          tick;
    logic                                          expired;
    logic                                          preview;
    logic                                          leds_on;
    logic                                          rec_write;
    logic [`PLAYSEQ_ADDR_W-1:0]                    addr;
    logic [`PLAYSEQ_BANKS-1:0]                     bank_we;
    logic [`PLAYSEQ_BANKS-1:0][`PLAYSEQ_BTN_W-1:0] bank_data;

    playseq_control u_control (
        .clock(clock), .arst_n(arst_n), .start(start), .record(record),
        .pos(pos), .judge(judge), .tick(tick), .expired(expired),
        .cmd(cmd), .preview(preview), .leds_on(leds_on),
        .rec_write(rec_write), .status(status)
    );

    seq_addr_unit u_addr (
        .clock(clock), .arst_n(arst_n), .cmd(cmd), .level(level),
        .bank_sel(bank_sel), .rec_write(rec_write),
        .pos(pos), .addr(addr), .bank_we(bank_we)
    );

    play_timer u_timer (
        .clock(clock), .arst_n(arst_n), .cmd(cmd), .preview(preview),
        .speed(speed), .tick(tick), .expired(expired)
    );

    move_judge u_judge (
        .clock(clock), .arst_n(arst_n), .buttons(buttons),
        .bank_data(bank_data), .bank_sel(bank_sel), .preview(preview),
        .leds_on(leds_on), .judge(judge), .leds(leds)
    );

    // all banks share address and data, only the strobe differs
    for (genvar b = 0; b < `PLAYSEQ_BANKS; b++) begin : g_bank
        seq_bank u_bank (
            .clock(clock), .arst_n(arst_n), .we(bank_we[b]),
            .addr(addr), .wdata(buttons), .rdata(bank_data[b])
        );
    end

    // player is never asked for a step beyond those shown
    a_await_in_round: assert property (
        @(posedge clock) disable iff (!arst_n)
        (u_control.state == ST_AWAIT) |-> (addr <= pos.round)
    );

endmodule

// File: verif/tb_playseq.sv
//------------------------------
// testbench for the memory game, run from the project root
// stimulus and expected banks come from verif/playseq_patterns.txt
// status.round is checked as r-1 during round r
//------------------------------
`timescale 1ns/10ps
`include "playseq_defs.svh"

module tb_playseq;

    import playseq_pkg::*;

    logic         clock;
    logic         arst_n;
    logic         start;
    logic         record;
    logic [1:0]   bank_sel;
    level_e       level;
    speed_e       speed;
    logic [3:0]   buttons;
    logic [3:0]   leds;
    game_status_t status;

    logic [3:0] model [`PLAYSEQ_BANKS][`PLAYSEQ_DEPTH];  // expected bank contents
    logic [3:0] steps [`PLAYSEQ_DEPTH];
    int         seed = 76;
    int         cyc;
    int         base_cyc;   // preview timing starts here
    int         rise_cyc;   // awaiting last rose here
    int         cur_bank;

    playseq_top dut (
        .clock(clock), .arst_n(arst_n), .start(start), .record(record),
        .bank_sel(bank_sel), .level(level), .speed(speed), .buttons(buttons),
        .leds(leds), .status(status)
    );

    always #20 clock = ~clock;

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;  // drive point
        cyc++;
    endtask

    function automatic logic [3:0] flags();
        return {status.playing, status.awaiting, status.won, status.lost};
    endfunction

    task automatic check_flags(input logic [3:0] exp, input string what);
        assert (flags() == exp) else begin
            $display("mismatch status flags %s: got %h, exp %h", what, flags(), exp);
            stop_on_error();
        end
    endtask

    task automatic echo_check(input logic [3:0] v);
        #1;
        assert (leds == v) else begin
            $display("mismatch leds echo: got %h, exp %h", leds, v);
            stop_on_error();
        end
    endtask

    task automatic record_bank(input int b);
        int hold;
        bank_sel = 2'(b);
        record   = 1'b1;
        next_cycle();
        check_flags(4'b0000, "on entering record");  // won and lost cleared
        for (int k = 0; k < `PLAYSEQ_DEPTH; k++) begin
            buttons = steps[k];
            echo_check(steps[k]);
            hold = 1 + $unsigned($random(seed)) % 2;
            repeat (hold) next_cycle();
            buttons = '0;
            next_cycle();
            model[b][k] = steps[k];
        end
        record = 1'b0;
        next_cycle();
        next_cycle();
        check_flags(4'b0000, "after record");
    endtask

    task automatic watch_preview(input int r);
        int         seen;
        logic [3:0] prev;
        logic [3:0] exp_led;
        seen = 0;
        prev = '0;
        #1;  // leds follow a button release first
        while (!status.awaiting) begin
            assert (status.playing && (cyc - base_cyc) <= 2 * r * `PLAYSEQ_PREVIEW_TICKS + 2 * r + 4)
            else begin
                $display("timeout: preview of round %0d did not reach the press phase", r);
                stop_on_error();
            end
            if (leds != '0 && prev == '0) begin  // a new step lights up
                exp_led = (seen < r) ? model[cur_bank][seen] : '0;
                assert (leds == exp_led) else begin
                    $display("mismatch leds in round %0d step %0d: got %h, exp %h",
                             r, seen, leds, exp_led);
                    stop_on_error();
                end
                seen++;
            end
            prev = leds;
            next_cycle();
        end
        assert (seen == r && (cyc - base_cyc) >= 2 * r * `PLAYSEQ_PREVIEW_TICKS) else begin
            $display("preview of round %0d showed %0d steps in %0d cycles", r, seen, cyc - base_cyc);
            stop_on_error();
        end
        assert (status.round == 4'(r - 1)) else begin
            $display("mismatch status.round: got %h, exp %h", status.round, 4'(r - 1));
            stop_on_error();
        end
        rise_cyc = cyc;
    endtask

    // decision shows two cycles after the press pulse
    task automatic press_step(input logic [3:0] v, input logic [3:0] exp);
        int hold;
        check_flags(4'b1100, "before press");
        buttons = v;
        echo_check(v);
        next_cycle();
        check_flags(4'b1000, "one cycle after press");
        next_cycle();
        check_flags(exp, "two cycles after press");
        rise_cyc = cyc;
        base_cyc = cyc;
        hold = $unsigned($random(seed)) % 3;  // press length jitter
        repeat (hold) next_cycle();
        check_flags(exp, "while press held");
        buttons = '0;
    endtask

    task automatic stall_until_lost(input int limit);
        while (!status.lost) begin
            assert (cyc - rise_cyc <= limit + 3) else begin
                $display("timeout: lost did not rise within %0d cycles of awaiting", limit + 3);
                stop_on_error();
            end
            next_cycle();
        end
        assert (cyc - rise_cyc >= limit) else begin
            $display("mismatch status.lost delay: got %h, exp at least %h", cyc - rise_cyc, limit);
            stop_on_error();
        end
        check_flags(4'b0001, "after timeout");
    endtask

    task automatic play_game(input bit stall, input int fault);
        int         fr;
        int         limit;
        int         gap;
        bit         hit;
        bit         over;
        logic [3:0] v;
        logic [3:0] exp;
        fr    = 4 * (int'(level) + 1);  // final round of the level
        limit = `PLAYSEQ_TIMEOUT_BASE * (8 >> int'(speed));
        over  = 1'b0;
        assert (fault <= fr) else begin
            $display("pattern fault %0d lies beyond final round %0d", fault, fr);
            stop_on_error();
        end
        bank_sel = 2'(cur_bank);
        start    = 1'b1;
        base_cyc = cyc;
        next_cycle();
        start = 1'b0;
        for (int r = 1; r <= fr && !over; r++) begin
            watch_preview(r);
            for (int k = 0; k < r && !over; k++) begin
                hit = (r == fr && k == fault - 1) || (stall && fault == 0 && r == 1);
                if (stall && hit) begin
                    stall_until_lost(limit);
                    over = 1'b1;
                end else begin
                    gap = (k > 0 ? 1 : 0) + $unsigned($random(seed)) % 2;
                    repeat (gap) next_cycle();
                    v = model[cur_bank][k];
                    if (hit) begin
                        v    = {v[2:0], v[3]};  // some other button
                        exp  = 4'b0001;
                        over = 1'b1;
                    end else if (k < r - 1) begin
                        exp = 4'b1100;
                    end else begin
                        exp = (r < fr) ? 4'b1000 : 4'b0010;
                    end
                    press_step(v, exp);
                end
            end
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int            fd;
        int            code;
        int            lvl;
        int            spd;
        int            fault;
        int            lines;
        logic [63:0]   op;
        logic [1023:0] rest;
        clock    = 1'b0;
        arst_n   = 1'b0;
        start    = 1'b0;
        record   = 1'b0;
        bank_sel = '0;
        level    = LVL_EASY;
        speed    = SPD_RELAXED;
        buttons  = '0;
        cyc      = 0;
        lines    = 0;
        repeat (16) @(posedge clock);
        #2;
        arst_n = 1'b1;
        next_cycle();
        check_flags(4'b0000, "after reset");
        echo_check(4'h0);
        fd = $fopen("verif/playseq_patterns.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the pattern file");
            stop_on_error();
        end
        while ($fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                code = $fgets(rest, fd);  // column notes
            end else begin
                code = $fscanf(fd, "%d %d %d", cur_bank, lvl, spd);
                for (int k = 0; k < `PLAYSEQ_DEPTH; k++) begin
                    code = $fscanf(fd, "%h", steps[k]);
                end
                code  = $fscanf(fd, "%d", fault);
                level = level_e'(lvl[1:0]);
                speed = speed_e'(spd[1:0]);
                assert (code == 1 && (op == "REC" || op == "PLAY" || op == "TIMEOUT")) else begin
                    $display("pattern line %0d cannot be read", lines + 1);
                    stop_on_error();
                end
                if (op == "REC") begin
                    record_bank(cur_bank);
                end else begin
                    play_game(op == "TIMEOUT", fault);
                end
                next_cycle();
                lines++;
            end
        end
        $fclose(fd);
        assert (lines > 0) else begin
            $display("pattern file holds no test cases");
            stop_on_error();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: verif/playseq_patterns.txt
# op bank level(0 easy..3 expert) speed(0 relaxed..3 frantic), steps 0..15 in hex, fault f
# PLAY f>0 presses a wrong button at press f of the final round; TIMEOUT stops pressing there (f=0 round 1)
REC     0 0 0  1 2 4 8 1 2 4 8 1 2 4 8 1 2 4 8  0
REC     1 0 0  8 4 2 1 8 4 2 1 8 4 2 1 8 4 2 1  0
REC     2 0 0  1 1 2 2 4 4 8 8 1 1 2 2 4 4 8 8  0
REC     3 0 0  4 8 1 2 2 1 8 4 4 1 2 8 8 2 1 4  0
PLAY    0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0
PLAY    1 1 1  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0
PLAY    2 2 2  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0
PLAY    3 3 3  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0
PLAY    1 0 3  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  2
PLAY    2 1 0  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  8
PLAY    3 0 1  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1
PLAY    0 2 2  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  6
TIMEOUT 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0
TIMEOUT 1 0 1  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0
TIMEOUT 2 0 2  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0
TIMEOUT 3 0 3  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0
TIMEOUT 2 1 3  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  5
REC     0 0 0  2 8 4 1 1 4 8 2 2 2 8 8 4 1 4 1  0
PLAY    0 1 3  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0
PLAY    1 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0

// File: sim.f
+incdir+rtl
rtl/playseq_pkg.sv
rtl/seq_bank.sv
rtl/seq_addr_unit.sv
rtl/move_judge.sv
rtl/play_timer.sv
rtl/playseq_control.sv
rtl/playseq_top.sv
verif/tb_playseq.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory game testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_playseq -o tb_playseq
out=$(./obj_dir/tb_playseq 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
    echo "run_sim: passed"
else
    echo "run_sim: failed"
    exit 1
fi
